/* Bender.yml */
package:
  name: apio

sources:
  - design/apio_pkg.sv
  - design/apio_axil_pkg.sv
  - design/apio_axil_regs.sv
  - design/apio_gpio.sv
  - design/apio_pin_mux.sv
  - design/apio_top.sv
  - target: any(test, simulation)
    files:
      - verif/apio_assertions.sv
      - verif/apio_tb.sv

/* design/apio_axil_pkg.sv */
// ********************
// Bus-side types of the adaptable pin block
// AXI4-Lite channel structs, response codes and register map
// ********************

package apio_axil_pkg;

	localparam int addr_w = 8;
	localparam int data_w = 32;

	// Master-driven signals
	typedef struct packed
	{
		// Write address
		logic              awvalid;
		logic [addr_w-1:0] awaddr;
		// Write data
		logic              wvalid;
		logic [data_w-1:0] wdata;
		logic [3:0]        wstrb;
		// Write response
		logic              bready;
		// Read address
		logic              arvalid;
		logic [addr_w-1:0] araddr;
		// Read data
		logic              rready;
	} axil_req_t;

	// Slave-driven signals
	typedef struct packed
	{
		logic              awready;
		logic              wready;
		logic              bvalid;
		logic [1:0]        bresp;
		logic              arready;
		logic              rvalid;
		logic [data_w-1:0] rdata;
		logic [1:0]        rresp;
	} axil_rsp_t;

	localparam logic [1:0] resp_okay   = 2'b00;
	localparam logic [1:0] resp_slverr = 2'b10;

	// ********************
	// Register map
	// ********************
	localparam logic [addr_w-1:0] reg_if_type = 8'h00;

	// Channel n block sits at reg_ch_base + n * reg_ch_stride
	localparam logic [addr_w-1:0] reg_ch_base    = 8'h10;
	localparam logic [addr_w-1:0] reg_ch_stride  = 8'h10;
	localparam logic [addr_w-1:0] reg_oe         = 8'h00;
	localparam logic [addr_w-1:0] reg_out        = 8'h04;
	localparam logic [addr_w-1:0] reg_in         = 8'h08;
	localparam logic [addr_w-1:0] reg_irq_status = 8'h0C;

	// Interrupt enables, one word per channel, enable in bit 0
	localparam logic [addr_w-1:0] reg_irq_en_base   = 8'h30;
	localparam logic [addr_w-1:0] reg_irq_en_stride = 8'h04;

endpackage

/* design/apio_axil_regs.sv */
// ********************
// AXI4-Lite register block of the pin block
// Holds the function select and the GPIO channel controls
// ********************

`timescale 1ns/1ns

module apio_axil_regs
(
	input  logic                     clk,
	input  logic                     rst_n,
	input  apio_axil_pkg::axil_req_t axil_req,
	output apio_axil_pkg::axil_rsp_t axil_rsp,
	output apio_pkg::aioif_type_e    if_type,
	output apio_pkg::gpio_cfg_t      gpio_cfg [apio_pkg::num_pads],
	input  apio_pkg::gpio_stat_t     gpio_stat [apio_pkg::num_pads]
);

	import apio_pkg::*;
	import apio_axil_pkg::*;

	// Address of a register inside the block of channel ch
	function automatic logic [addr_w-1:0] ch_addr(input int unsigned ch,
		input logic [addr_w-1:0] ofs);
		return addr_w'(reg_ch_base + reg_ch_stride * ch) + ofs;
	endfunction

	// Address of the interrupt enable word of channel ch
	function automatic logic [addr_w-1:0] en_addr(input int unsigned ch);
		return addr_w'(reg_irq_en_base + reg_irq_en_stride * ch);
	endfunction

	// Control registers
	aioif_type_e         if_type_q;
	logic [num_pads-1:0] oe_q;
	logic [num_pads-1:0] out_q;
	logic [num_pads-1:0] irq_en_q;
	logic [num_pads-1:0] irq_clr_q;

	// Handshake state and response payload
	logic                awready_q;
	logic                bvalid_q;
	logic [1:0]          bresp_q;
	logic                arready_q;
	logic                rvalid_q;
	logic [data_w-1:0]   rdata_q;
	logic [1:0]          rresp_q;

	// Address decode
	logic                wr_fire;
	logic                rd_fire;
	logic                wr_hit;
	logic                wr_if;
	logic [num_pads-1:0] wr_oe;
	logic [num_pads-1:0] wr_out;
	logic [num_pads-1:0] wr_sts;
	logic [num_pads-1:0] wr_en;
	logic                rd_hit;
	logic [data_w-1:0]   rd_data;

	assign wr_fire = awready_q && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = arready_q && axil_req.arvalid;

	// ********************
	// Decode
	// ********************
	always_comb
	begin
		wr_if = (axil_req.awaddr == reg_if_type);
		for (int n = 0; n < num_pads; n++)
		begin
			wr_oe[n]  = (axil_req.awaddr == ch_addr(n, reg_oe));
			wr_out[n] = (axil_req.awaddr == ch_addr(n, reg_out));
			wr_sts[n] = (axil_req.awaddr == ch_addr(n, reg_irq_status));
			wr_en[n]  = (axil_req.awaddr == en_addr(n));
		end
		// reg_in is read only and answers a write with an error
		wr_hit = wr_if || (|wr_oe) || (|wr_out) || (|wr_sts) || (|wr_en);
	end

	always_comb
	begin
		rd_hit  = (axil_req.araddr == reg_if_type);
		rd_data = rd_hit ? data_w'(if_type_q) : '0;
		for (int n = 0; n < num_pads; n++)
		begin
			if (axil_req.araddr == ch_addr(n, reg_oe))
			begin
				rd_hit     = 1'b1;
				rd_data[0] = oe_q[n];
			end
			if (axil_req.araddr == ch_addr(n, reg_out))
			begin
				rd_hit     = 1'b1;
				rd_data[0] = out_q[n];
			end
			if (axil_req.araddr == ch_addr(n, reg_in))
			begin
				rd_hit     = 1'b1;
				rd_data[0] = gpio_stat[n].in_val;
			end
			if (axil_req.araddr == ch_addr(n, reg_irq_status))
			begin
				rd_hit     = 1'b1;
				rd_data[0] = gpio_stat[n].irq_pending;
			end
			if (axil_req.araddr == en_addr(n))
			begin
				rd_hit     = 1'b1;
				rd_data[0] = irq_en_q[n];
			end
		end
	end

	// ********************
	// Handshake and registers
	// ********************
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			awready_q <= 1'b0;
			bvalid_q  <= 1'b0;
			arready_q <= 1'b0;
			rvalid_q  <= 1'b0;
			if_type_q <= aioif_gpio;
			oe_q      <= '0;
			out_q     <= '0;
			irq_en_q  <= '0;
			irq_clr_q <= '0;
		end
		else
		begin
			// One ready cycle per request, none while a response waits
			awready_q <= axil_req.awvalid && axil_req.wvalid && !awready_q && !bvalid_q;
			arready_q <= axil_req.arvalid && !arready_q && !rvalid_q;
			irq_clr_q <= '0;

			if (wr_fire)
				bvalid_q <= 1'b1;
			else if (axil_req.bready)
				bvalid_q <= 1'b0;

			if (rd_fire)
				rvalid_q <= 1'b1;
			else if (axil_req.rready)
				rvalid_q <= 1'b0;

			if (wr_fire && axil_req.wstrb[0])
			begin
				if (wr_if)
					if_type_q <= aioif_type_e'(axil_req.wdata[1:0]);
				for (int n = 0; n < num_pads; n++)
				begin
					if (wr_oe[n])
						oe_q[n] <= axil_req.wdata[0];
					if (wr_out[n])
						out_q[n] <= axil_req.wdata[0];
					if (wr_en[n])
						irq_en_q[n] <= axil_req.wdata[0];
					// Write one to clear
					if (wr_sts[n])
						irq_clr_q[n] <= axil_req.wdata[0];
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_fire)
			bresp_q <= wr_hit ? resp_okay : resp_slverr;
		if (rd_fire)
		begin
			rresp_q <= rd_hit ? resp_okay : resp_slverr;
			rdata_q <= rd_data;
		end
	end

	// Outputs
	always_comb
	begin
		axil_rsp.awready = awready_q;
		axil_rsp.wready  = awready_q;
		axil_rsp.bvalid  = bvalid_q;
		axil_rsp.bresp   = bresp_q;
		axil_rsp.arready = arready_q;
		axil_rsp.rvalid  = rvalid_q;
		axil_rsp.rdata   = rdata_q;
		axil_rsp.rresp   = rresp_q;
		for (int n = 0; n < num_pads; n++)
		begin
			gpio_cfg[n].oe        = oe_q[n];
			gpio_cfg[n].out_val   = out_q[n];
			gpio_cfg[n].irq_en    = irq_en_q[n];
			gpio_cfg[n].irq_clear = irq_clr_q[n];
		end
	end

	assign if_type = if_type_q;

endmodule

/* design/apio_gpio.sv */
// ********************
// One GPIO channel
// Synchronizes its pad, samples it on a tick and flags changes
// ********************

`timescale 1ns/1ns

module apio_gpio
#(
	parameter int tick_period = 8
)
(
	input  logic                 clk,
	input  logic                 rst_n,
	input  apio_pkg::gpio_cfg_t  cfg,
	output apio_pkg::gpio_stat_t stat,
	output logic                 pad_oe,
	output logic                 pad_out,
	input  logic                 pad_in,
	output logic                 irq
);

	localparam int cnt_w = (tick_period > 1) ? $clog2(tick_period) : 1;

	logic [cnt_w-1:0] tick_cnt;
	logic             tick;
	logic [1:0]       sync_q;
	logic             sample_q;
	logic             pending_q;

	// Free-running sample tick
	assign tick = (tick_cnt == cnt_w'(tick_period - 1));

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			tick_cnt <= '0;
		else if (tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// ********************
	// Input path
	// ********************
	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			sync_q    <= '0;
			sample_q  <= 1'b0;
			pending_q <= 1'b0;
		end
		else
		begin
			sync_q <= {sync_q[0], pad_in};
			if (tick)
				sample_q <= sync_q[1];

			// Clear has priority over a change seen on the same tick
			if (cfg.irq_clear)
				pending_q <= 1'b0;
			else if (tick && (sync_q[1] != sample_q))
				pending_q <= 1'b1;
		end
	end

	assign stat.in_val      = sample_q;
	assign stat.irq_pending = pending_q;
	assign irq              = pending_q && cfg.irq_en;

	// Output request straight from the registers
	assign pad_oe  = cfg.oe;
	assign pad_out = cfg.out_val;

endmodule

/* design/apio_pin_mux.sv */
// ********************
// Pad multiplexer
// Routes both pads to the selected function
// ********************

`timescale 1ns/1ns

module apio_pin_mux
(
	input  apio_pkg::aioif_type_e          if_type,
	input  logic [apio_pkg::num_pads-1:0]  gpio_oe,
	input  logic [apio_pkg::num_pads-1:0]  gpio_out,
	output logic [apio_pkg::num_pads-1:0]  gpio_in,
	input  apio_pkg::serial_out_t          ser_out,
	output apio_pkg::serial_in_t           ser_in,
	output apio_pkg::pad_out_t             pads,
	input  logic [apio_pkg::num_pads-1:0]  pad_in
);

	import apio_pkg::*;

	always_comb
	begin
		// Unselected inputs read zero and idle pads float
		pads    = '0;
		gpio_in = '0;
		ser_in  = '0;

		case (if_type)
			aioif_gpio:
			begin
				pads.oe  = gpio_oe;
				pads.out = gpio_out;
				gpio_in  = pad_in;
			end

			// Pad 0 drives and pad 1 listens
			aioif_spi:
			begin
				pads.oe[0]      = 1'b1;
				pads.out[0]     = ser_out.spi_mosi;
				ser_in.spi_miso = pad_in[1];
			end

			aioif_uart:
			begin
				pads.oe[0]     = 1'b1;
				pads.out[0]    = ser_out.uart_tx;
				ser_in.uart_rx = pad_in[1];
			end

			// SCL on pad 0, SDA on pad 1, open drain
			aioif_i2c:
			begin
				pads.oe[0]       = ~ser_out.i2c_scl_t;
				pads.out[0]      = ser_out.i2c_scl_o;
				ser_in.i2c_scl_i = pad_in[0];
				pads.oe[1]       = ~ser_out.i2c_sda_t;
				pads.out[1]      = ser_out.i2c_sda_o;
				ser_in.i2c_sda_i = pad_in[1];
			end

			default:
			begin
				pads = '0;
			end
		endcase
	end

endmodule

/* design/apio_pkg.sv */
// ********************
// Pin-side types of the adaptable pin block
// Pads, function select, serial lines and GPIO channel structs
// ********************

package apio_pkg;

	// Physical pads in the block
	localparam int num_pads = 2;

	// Function that owns both pads
	typedef enum logic [1:0]
	{
		aioif_gpio = 2'd0,
		aioif_spi  = 2'd1,
		aioif_uart = 2'd2,
		aioif_i2c  = 2'd3
	} aioif_type_e;

	// Drive side of the pad set
	typedef struct packed
	{
		logic [num_pads-1:0] oe;
		logic [num_pads-1:0] out;
	} pad_out_t;

	// Lines driven by the external serial controllers
	typedef struct packed
	{
		logic spi_mosi;
		logic uart_tx;
		// I2C lines are open drain, t releases the line
		logic i2c_scl_o;
		logic i2c_scl_t;
		logic i2c_sda_o;
		logic i2c_sda_t;
	} serial_out_t;

	// Lines returned to the external serial controllers
	typedef struct packed
	{
		logic spi_miso;
		logic uart_rx;
		logic i2c_scl_i;
		logic i2c_sda_i;
	} serial_in_t;

	// Register view of one GPIO channel, irq_clear is a single-cycle pulse
	typedef struct packed
	{
		logic oe;
		logic out_val;
		logic irq_en;
		logic irq_clear;
	} gpio_cfg_t;

	// Channel status read back by the registers
	typedef struct packed
	{
		logic in_val;
		logic irq_pending;
	} gpio_stat_t;

endpackage

/* design/apio_top.sv */
// ********************
// Adaptable pin block top
// Register block, two GPIO channels and the pad multiplexer
// ********************

`timescale 1ns/1ns

module apio_top
#(
	parameter int tick_period = 8
)
(
	input  logic                          clk,
	input  logic                          rst_n,
	input  apio_axil_pkg::axil_req_t      axil_req,
	output apio_axil_pkg::axil_rsp_t      axil_rsp,
	input  apio_pkg::serial_out_t         ser_out,
	output apio_pkg::serial_in_t          ser_in,
	output apio_pkg::pad_out_t            pads,
	input  logic [apio_pkg::num_pads-1:0] pad_in,
	output logic [apio_pkg::num_pads-1:0] gpio_irq
);

	import apio_pkg::*;

	aioif_type_e         if_type;
	gpio_cfg_t           gpio_cfg  [num_pads];
	gpio_stat_t          gpio_stat [num_pads];
	logic [num_pads-1:0] gpio_oe;
	logic [num_pads-1:0] gpio_out;
	logic [num_pads-1:0] gpio_in;

	// ********************
	// Registers
	// ********************
	apio_axil_regs u_regs
	(
		.clk       (clk),
		.rst_n     (rst_n),
		.axil_req  (axil_req),
		.axil_rsp  (axil_rsp),
		.if_type   (if_type),
		.gpio_cfg  (gpio_cfg),
		.gpio_stat (gpio_stat)
	);

	// One channel per pad
	generate
		for (genvar i = 0; i < num_pads; i++)
		begin : g_gpio
			apio_gpio
			#(
				.tick_period (tick_period)
			)
			u_gpio
			(
				.clk     (clk),
				.rst_n   (rst_n),
				.cfg     (gpio_cfg[i]),
				.stat    (gpio_stat[i]),
				.pad_oe  (gpio_oe[i]),
				.pad_out (gpio_out[i]),
				.pad_in  (gpio_in[i]),
				.irq     (gpio_irq[i])
			);
		end
	endgenerate

	// ********************
	// Pad routing
	// ********************
	apio_pin_mux u_pin_mux
	(
		.if_type  (if_type),
		.gpio_oe  (gpio_oe),
		.gpio_out (gpio_out),
		.gpio_in  (gpio_in),
		.ser_out  (ser_out),
		.ser_in   (ser_in),
		.pads     (pads),
		.pad_in   (pad_in)
	);

endmodule

/* verif/apio_assertions.sv */
// ********************
// Bus handshake assertions
// Bound to the AXI4-Lite register block
// ********************

`timescale 1ns/1ns

module apio_assertions
(
	input logic                     clk,
	input logic                     rst_n,
	input apio_axil_pkg::axil_req_t axil_req,
	input apio_axil_pkg::axil_rsp_t axil_rsp,
	input apio_pkg::aioif_type_e    if_type
);

	// Write response holds until taken
	a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.bvalid && !axil_req.bready |=> axil_rsp.bvalid && $stable(axil_rsp.bresp))
		else $error("Write response changed before bready");

	// Read data holds until taken
	a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
		axil_rsp.rvalid && !axil_req.rready |=> axil_rsp.rvalid && $stable(axil_rsp.rdata))
		else $error("Read data changed before rready");

	// A read response needs an accepted read address
	a_r_cause: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(axil_rsp.rvalid) |-> $past(axil_rsp.arready && axil_req.arvalid))
		else $error("rvalid rose without an accepted read");

	a_if_known: assert property (@(posedge clk) disable iff (!rst_n)
		!$isunknown(if_type))
		else $error("Function select is unknown");

endmodule

bind apio_axil_regs apio_assertions u_assertions
(
	.clk      (clk),
	.rst_n    (rst_n),
	.axil_req (axil_req),
	.axil_rsp (axil_rsp),
	.if_type  (if_type)
);

/* verif/apio_tb.sv */
// ********************
// Testbench of the adaptable pin block
// Directed tests over the AXI4-Lite port, GPIO, interrupts and pad routing
// ********************

`timescale 1ns/1ns

module apio_tb;

	import apio_pkg::*;
	import apio_axil_pkg::*;

	localparam int tick_period = 8;
	localparam int wait_limit  = 100;
	localparam int poll_limit  = 20;

	logic                clk;
	logic                rst_n;
	axil_req_t           axil_req;
	axil_rsp_t           axil_rsp;
	serial_out_t         ser_out;
	serial_in_t          ser_in;
	pad_out_t            pads;
	logic [num_pads-1:0] pad_in;
	logic [num_pads-1:0] gpio_irq;

	int errors;
	int checks;
	int seed;

	apio_top
	#(
		.tick_period (tick_period)
	)
	DUT
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.ser_out  (ser_out),
		.ser_in   (ser_in),
		.pads     (pads),
		.pad_in   (pad_in),
		.gpio_irq (gpio_irq)
	);

	initial
		clk = 1'b0;

	always #2 clk = ~clk;

	// Channel register address from block base 0x10 and stride 0x10
	function automatic logic [7:0] chan_addr(input int ch, input logic [7:0] ofs);
		return 8'h10 + 8'h10 * ch[7:0] + ofs;
	endfunction

	// Interrupt enable word of a channel
	function automatic logic [7:0] irq_en_addr(input int ch);
		return 8'h30 + 8'h04 * ch[7:0];
	endfunction

	task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp, act);
			errors++;
		end
	endtask

	// ********************
	// Bus tasks
	// ********************
	// hold keeps bready low for that many cycles once bvalid is up
	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data, input int hold,
		output logic [1:0] resp);
		int         cnt;
		logic [1:0] first;
		@(posedge clk);
		axil_req.awvalid <= 1'b1;
		axil_req.awaddr  <= addr;
		axil_req.wvalid  <= 1'b1;
		axil_req.wdata   <= data;
		axil_req.wstrb   <= 4'hF;
		axil_req.bready  <= (hold == 0);
		cnt = 0;
		do
		begin
			@(posedge clk);
			cnt++;
		end
		while (!axil_rsp.awready && cnt < wait_limit);
		axil_req.awvalid <= 1'b0;
		axil_req.wvalid  <= 1'b0;
		if (!axil_rsp.awready)
		begin
			$display("Timeout waiting for awready at address %h", addr);
			errors++;
			resp = 2'b11;
			return;
		end
		check("wready with awready", 1, axil_rsp.wready);
		cnt = 0;
		do
		begin
			@(posedge clk);
			cnt++;
		end
		while (!axil_rsp.bvalid && cnt < wait_limit);
		if (!axil_rsp.bvalid)
		begin
			$display("Timeout waiting for bvalid at address %h", addr);
			errors++;
			axil_req.bready <= 1'b1;
			resp = 2'b11;
			return;
		end
		if (hold > 0)
		begin
			first = axil_rsp.bresp;
			for (int i = 0; i < hold; i++)
			begin
				@(posedge clk);
				check("back-pressure bvalid", 1, axil_rsp.bvalid);
				check("back-pressure bresp", first, axil_rsp.bresp);
			end
			axil_req.bready <= 1'b1;
			@(posedge clk);
		end
		resp = axil_rsp.bresp;
	endtask

	task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
		output logic [1:0] resp);
		int cnt;
		@(posedge clk);
		axil_req.arvalid <= 1'b1;
		axil_req.araddr  <= addr;
		axil_req.rready  <= 1'b1;
		cnt = 0;
		do
		begin
			@(posedge clk);
			cnt++;
		end
		while (!axil_rsp.arready && cnt < wait_limit);
		axil_req.arvalid <= 1'b0;
		if (!axil_rsp.arready)
		begin
			$display("Timeout waiting for arready at address %h", addr);
			errors++;
			data = '0;
			resp = 2'b11;
			return;
		end
		cnt = 0;
		do
		begin
			@(posedge clk);
			cnt++;
		end
		while (!axil_rsp.rvalid && cnt < wait_limit);
		if (!axil_rsp.rvalid)
		begin
			$display("Timeout waiting for rvalid at address %h", addr);
			errors++;
			data = '0;
			resp = 2'b11;
			return;
		end
		data = axil_rsp.rdata;
		resp = axil_rsp.rresp;
	endtask

	// Read a register until it shows the expected value
	task automatic poll_reg(input string name, input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] data;
		logic [1:0]  resp;
		int          tries;
		tries = 0;
		do
		begin
			axil_read(addr, data, resp);
			tries++;
		end
		while (data !== exp && tries < poll_limit);
		if (data !== exp)
			$display("Timeout polling address %h", addr);
		check(name, exp, data);
	endtask

	// Wait for one interrupt line to reach a level
	task automatic wait_irq(input int ch, input logic level);
		int cnt;
		cnt = 0;
		while (gpio_irq[ch] !== level && cnt < wait_limit)
		begin
			@(posedge clk);
			cnt++;
		end
		if (gpio_irq[ch] !== level)
		begin
			$display("Timeout waiting for gpio_irq of channel %0d to go %0b", ch, level);
			errors++;
		end
	endtask

	// ********************
	// Tests
	// ********************
	task automatic reset_state_test();
		logic [31:0] data;
		logic [1:0]  resp;
		check("reset pads oe", 0, pads.oe);
		check("reset gpio_irq", 0, gpio_irq);
		axil_read(8'h00, data, resp);
		check("reset if_type", 0, data);
		check("reset if_type resp", resp_okay, resp);
		for (int n = 0; n < num_pads; n++)
		begin
			axil_read(chan_addr(n, 8'h00), data, resp);
			check("reset oe", 0, data);
			check("reset oe resp", resp_okay, resp);
			axil_read(chan_addr(n, 8'h0C), data, resp);
			check("reset irq status", 0, data);
			check("reset irq status resp", resp_okay, resp);
		end
	endtask

	task automatic gpio_io_test();
		logic [31:0]         r;
		logic [1:0]          resp;
		logic [num_pads-1:0] oe_v;
		logic [num_pads-1:0] out_v;
		logic [num_pads-1:0] pv;
		for (int n = 0; n < num_pads; n++)
		begin
			r = $random(seed);
			oe_v[n]  = r[0];
			out_v[n] = r[1];
			axil_write(chan_addr(n, 8'h00), {31'b0, oe_v[n]}, 0, resp);
			check("gpio oe write resp", resp_okay, resp);
			axil_write(chan_addr(n, 8'h04), {31'b0, out_v[n]}, 0, resp);
			check("gpio out write resp", resp_okay, resp);
		end
		@(posedge clk);
		check("gpio pads oe", oe_v, pads.oe);
		check("gpio pads out", out_v, pads.out);

		r = $random(seed);
		pv = r[num_pads-1:0];
		// At least one pad has to move away from its reset level
		if (pv == '0)
			pv = '1;
		pad_in <= pv;
		for (int n = 0; n < num_pads; n++)
			poll_reg("gpio reg_in", chan_addr(n, 8'h08), pv[n]);
		// A changed pad is pending here, but no interrupt is enabled
		check("gpio_irq without enable", 0, gpio_irq);
		// Leave both channels without a pending change
		for (int n = 0; n < num_pads; n++)
			axil_write(chan_addr(n, 8'h0C), 32'h1, 0, resp);
	endtask

	task automatic irq_test();
		logic [31:0] data;
		logic [31:0] r;
		logic [1:0]  resp;
		int          ch;
		r  = $random(seed);
		ch = r[0];
		axil_write(irq_en_addr(ch), 32'h1, 0, resp);
		check("irq enable resp", resp_okay, resp);
		pad_in[ch] <= ~pad_in[ch];
		wait_irq(ch, 1'b1);
		check("irq one channel", 2'b01 << ch, gpio_irq);
		axil_read(chan_addr(ch, 8'h0C), data, resp);
		check("irq status set", 1, data);

		axil_write(chan_addr(ch, 8'h0C), 32'h1, 0, resp);
		check("irq clear resp", resp_okay, resp);
		wait_irq(ch, 1'b0);
		check("irq cleared", 0, gpio_irq);
		axil_read(chan_addr(ch, 8'h0C), data, resp);
		check("irq status cleared", 0, data);
		axil_write(irq_en_addr(ch), 32'h0, 0, resp);
	endtask

	task automatic function_switch_test();
		aioif_type_e         fn;
		serial_out_t         so;
		serial_in_t          exp_in;
		logic [31:0]         r;
		logic [1:0]          resp;
		logic [num_pads-1:0] pv;
		logic [num_pads-1:0] exp_oe;
		logic [num_pads-1:0] exp_out;
		for (int k = 1; k < 4; k++)
		begin
			fn = aioif_type_e'(k);
			axil_write(8'h00, k, 0, resp);
			check("select resp", resp_okay, resp);
			r  = $random(seed);
			so = r[5:0];
			pv = r[9:8];
			ser_out <= so;
			pad_in  <= pv;
			@(posedge clk);
			@(posedge clk);

			exp_in = '0;
			case (fn)
				aioif_spi:
				begin
					exp_oe          = 2'b01;
					exp_out         = {1'b0, so.spi_mosi};
					exp_in.spi_miso = pv[1];
				end
				aioif_uart:
				begin
					exp_oe         = 2'b01;
					exp_out        = {1'b0, so.uart_tx};
					exp_in.uart_rx = pv[1];
				end
				default:
				begin
					// A released open-drain line is not driven
					exp_oe           = {~so.i2c_sda_t, ~so.i2c_scl_t};
					exp_out          = {so.i2c_sda_o, so.i2c_scl_o};
					exp_in.i2c_scl_i = pv[0];
					exp_in.i2c_sda_i = pv[1];
				end
			endcase
			check($sformatf("%s pads oe", fn.name()), exp_oe, pads.oe);
			check($sformatf("%s pads out", fn.name()), exp_out, pads.out);
			check($sformatf("%s ser_in", fn.name()), exp_in, ser_in);
			check($sformatf("%s gpio in", fn.name()), 0, DUT.gpio_in);
		end
	endtask

	task automatic bus_error_test();
		logic [31:0] data;
		logic [1:0]  resp;
		axil_read(8'h40, data, resp);
		check("unmapped read resp", resp_slverr, resp);
		check("unmapped read data", 0, data);
		axil_write(8'h40, 32'h1, 0, resp);
		check("unmapped write resp", resp_slverr, resp);
		axil_write(chan_addr(0, 8'h08), 32'h1, 0, resp);
		check("read-only write resp", resp_slverr, resp);

		// Response waits while bready stays low
		axil_write(8'h00, 32'h2, 6, resp);
		check("held write resp", resp_okay, resp);
		axil_write(8'h44, 32'h3, 0, resp);
		check("unmapped write after hold", resp_slverr, resp);
		axil_read(8'h00, data, resp);
		check("if_type after hold", 2, data);
		check("if_type after hold resp", resp_okay, resp);
	endtask

	initial
	begin
		seed            = 98965;
		errors          = 0;
		checks          = 0;
		rst_n           = 1'b0;
		axil_req        = '0;
		axil_req.bready = 1'b1;
		axil_req.rready = 1'b1;
		ser_out         = '0;
		pad_in          = '0;
		repeat (3) @(posedge clk);
		rst_n <= 1'b1;
		@(posedge clk);

		reset_state_test();
		gpio_io_test();
		irq_test();
		function_switch_test();
		bus_error_test();

		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

/* verilog.f */
design/apio_pkg.sv
design/apio_axil_pkg.sv
design/apio_axil_regs.sv
design/apio_gpio.sv
design/apio_pin_mux.sv
design/apio_top.sv
verif/apio_assertions.sv
verif/apio_tb.sv
